// File: design/hdc_cfg_pkg.sv
package hdc_cfg_pkg;

    // load words and instruction words share one width
    localparam int WORD_W = 32;

    // default hypervector length in bits
    localparam int HV_BITS_DFLT = 1024;

    // default item memory depth
    localparam int ITEMS_DFLT = 512;

    // default number of hardware threads
    localparam int THREADS_DFLT = 5;

endpackage

// File: design/hdc_isa_pkg.sv
package hdc_isa_pkg;

    // rotate amount, low bits double as item address
    localparam int SHIFT_W = 10;

    // src_sel bit positions, lowest wins
    localparam int SRC_ITEM        = 0;
    localparam int SRC_XOR         = 1;
    localparam int SRC_PERM_XOR_R2 = 2;
    localparam int SRC_PERM_XOR_R1 = 3;
    localparam int SRC_SWAP        = 4;
    localparam int SRC_PERM        = 5;

    // out_sel bit positions
    localparam int OUT_R2   = 0;
    localparam int OUT_R1   = 1;
    localparam int OUT_PERM = 2;
    localparam int OUT_LAST = 3;

    // one instruction word, decoded by is_out
    typedef union packed {
        struct packed {
            logic                 wr_r1;
            logic                 wr_r2;
            logic                 rsv_29;
            logic                 is_out;
            logic [ 9:0 ]         rsv_27_18;
            logic [ 5:0 ]         src_sel;
            logic [ 1:0 ]         rsv_11_10;
            logic [ SHIFT_W-1:0 ] shift;
        } cmp;
        struct packed {
            logic [ 2:0 ]         rsv_31_29;
            logic                 is_out;
            logic [ 11:0 ]        rsv_27_16;
            logic [ 3:0 ]         out_sel;
            // shift still lives in bits 9..0 for a perm output
            logic [ 11:0 ]        rsv_11_0;
        } out;
    } hdc_instr_u;

    // next value of a thread register
    typedef enum logic [ 2:0 ] {
        NXT_ITEM, NXT_XOR, NXT_PERM_XOR_R2, NXT_PERM_XOR_R1, NXT_R1, NXT_R2, NXT_PERM
    } nxt_sel_e;

    // vector sent to the result port
    typedef enum logic [ 1:0 ] {
        OSEL_R2, OSEL_R1, OSEL_PERM
    } out_sel_e;

endpackage

// File: design/item_loader.sv
`timescale 1ns/100ps

module item_loader
    import hdc_cfg_pkg::*;
#(
    parameter int  HV_BITS = HV_BITS_DFLT,
    parameter int  ITEMS   = ITEMS_DFLT,
    localparam int ADDR_W  = $clog2( ITEMS )
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 load,
    input  logic                 load_valid,
    input  logic [ WORD_W-1:0 ]  load_word,
    output logic                 item_we,
    output logic [ ADDR_W-1:0 ]  item_waddr,
    output logic [ HV_BITS-1:0 ] item_wdata
);

    // 32-bit slices per hypervector
    localparam int WORDS = HV_BITS / WORD_W;
    localparam int CNT_W = ( WORDS > 1 ) ? $clog2( WORDS ) : 1;

    logic [ CNT_W-1:0 ] word_cnt;
    logic               last_word;

    assign last_word = ( word_cnt == CNT_W'( WORDS - 1 ) );

    always_ff @( posedge clk or negedge arst_n ) begin
        if ( !arst_n ) begin
            word_cnt   <= '0;
            item_we    <= 1'b0;
            item_waddr <= '0;
        end else begin
            // strobe one cycle after the final slice
            item_we <= load && load_valid && last_word;
            if ( !load ) begin
                word_cnt   <= '0;
                item_waddr <= '0;
            end else begin
                if ( load_valid )
                    word_cnt <= last_word ? '0 : word_cnt + 1'b1;
                if ( item_we )
                    item_waddr <= item_waddr + 1'b1;
            end
        end
    end

    // word k goes to bits k*32 upward
    always_ff @( posedge clk ) begin
        if ( load && load_valid ) begin
            item_wdata[ word_cnt*WORD_W +: WORD_W ] <= load_word;
        end
    end

    // item memory full, another item in the same load would overwrite item 0
    assert property ( @( posedge clk ) disable iff ( !arst_n )
        load && item_we |=> !load || item_waddr > $past( item_waddr ) );

endmodule

// File: design/item_memory.sv
`timescale 1ns/100ps

module item_memory
    import hdc_cfg_pkg::*;
#(
    parameter int  HV_BITS = HV_BITS_DFLT,
    parameter int  ITEMS   = ITEMS_DFLT,
    localparam int ADDR_W  = $clog2( ITEMS )
) (
    input  logic                 clk,
    input  logic                 item_we,
    input  logic [ ADDR_W-1:0 ]  item_waddr,
    input  logic [ HV_BITS-1:0 ] item_wdata,
    input  logic [ ADDR_W-1:0 ]  item_raddr,
    output logic [ HV_BITS-1:0 ] item_rdata
);

    logic [ HV_BITS-1:0 ] mem [ ITEMS ];

    always_ff @( posedge clk ) begin
        if ( item_we ) begin
            mem[ item_waddr ] <= item_wdata;
        end

        // read every cycle, lines up with the registered instruction
        // old data is returned on a same-address write
        item_rdata <= mem[ item_raddr ];
    end

endmodule

// File: design/hdc_sequencer.sv
`timescale 1ns/100ps

module hdc_sequencer
    import hdc_cfg_pkg::*;
    import hdc_isa_pkg::*;
#(
    parameter int  THREADS = THREADS_DFLT,
    localparam int TH_W    = $clog2( THREADS )
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 run,
    input  logic                 instr_valid,
    input  logic [ WORD_W-1:0 ]  instr_word,
    output logic [ TH_W-1:0 ]    thread,
    output logic                 wr_r1,
    output logic                 wr_r2,
    output logic [ SHIFT_W-1:0 ] shift,
    output nxt_sel_e             nxt_sel_r1,
    output nxt_sel_e             nxt_sel_r2,
    output logic                 out_valid,
    output out_sel_e             out_sel,
    output logic                 last_req
);

    logic [ TH_W-1:0 ] thread_cnt;
    hdc_instr_u        instr_q;
    nxt_sel_e          src;

    always_ff @( posedge clk or negedge arst_n ) begin
        if ( !arst_n ) begin
            thread_cnt <= '0;
            thread     <= '0;
            instr_q    <= '0;
        end else if ( !run ) begin
            // round robin restarts with the next run
            thread_cnt <= '0;
            instr_q    <= '0;
        end else if ( instr_valid ) begin
            instr_q    <= hdc_instr_u'( instr_word );
            thread     <= thread_cnt;
            thread_cnt <= ( thread_cnt == TH_W'( THREADS - 1 ) ) ? '0 : thread_cnt + 1'b1;
        end else begin
            // empty word decodes to a no-op
            instr_q <= '0;
        end
    end

    // same bit positions in both views
    assign shift = instr_q.cmp.shift;

    always_comb begin
        if ( instr_q.cmp.src_sel[ SRC_ITEM ] )
            src = NXT_ITEM;
        else if ( instr_q.cmp.src_sel[ SRC_XOR ] )
            src = NXT_XOR;
        else if ( instr_q.cmp.src_sel[ SRC_PERM_XOR_R2 ] )
            src = NXT_PERM_XOR_R2;
        else if ( instr_q.cmp.src_sel[ SRC_PERM_XOR_R1 ] )
            src = NXT_PERM_XOR_R1;
        else
            src = NXT_PERM;

        // swap hands each register the other one
        nxt_sel_r1 = instr_q.cmp.src_sel[ SRC_SWAP ] && src == NXT_PERM ? NXT_R2 : src;
        nxt_sel_r2 = instr_q.cmp.src_sel[ SRC_SWAP ] && src == NXT_PERM ? NXT_R1 : src;

        wr_r1 = !instr_q.cmp.is_out && instr_q.cmp.wr_r1;
        wr_r2 = !instr_q.cmp.is_out && instr_q.cmp.wr_r2;

        out_valid = instr_q.out.is_out && ( |instr_q.out.out_sel[ OUT_PERM:OUT_R2 ] );
        last_req  = instr_q.out.is_out && !out_valid && instr_q.out.out_sel[ OUT_LAST ];
        if ( instr_q.out.out_sel[ OUT_R2 ] )
            out_sel = OSEL_R2;
        else if ( instr_q.out.out_sel[ OUT_R1 ] )
            out_sel = OSEL_R1;
        else
            out_sel = OSEL_PERM;
    end

    // a compute word never names two sources
    assert property ( @( posedge clk ) disable iff ( !arst_n )
        !instr_q.cmp.is_out |-> $onehot0( instr_q.cmp.src_sel ) );

    // back to back words need two threads to avoid a register hazard
    assert property ( @( posedge clk ) THREADS >= 2 );

endmodule

// File: design/thread_regfile.sv
`timescale 1ns/100ps

module thread_regfile
    import hdc_cfg_pkg::*;
#(
    parameter int  HV_BITS = HV_BITS_DFLT,
    parameter int  THREADS = THREADS_DFLT,
    localparam int TH_W    = $clog2( THREADS )
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic [ TH_W-1:0 ]    thread,
    input  logic                 wr_r1,
    input  logic                 wr_r2,
    input  logic [ HV_BITS-1:0 ] next_r1,
    input  logic [ HV_BITS-1:0 ] next_r2,
    output logic [ HV_BITS-1:0 ] r1,
    output logic [ HV_BITS-1:0 ] r2
);

    // one entry per thread, kept across runs
    logic [ HV_BITS-1:0 ] bank_r1 [ THREADS ];
    logic [ HV_BITS-1:0 ] bank_r2 [ THREADS ];

    // writeback one cycle after the instruction is sampled
    always_ff @( posedge clk ) begin
        if ( wr_r1 ) begin
            bank_r1[ thread ] <= next_r1;
        end
        if ( wr_r2 ) begin
            bank_r2[ thread ] <= next_r2;
        end
    end

    // current thread operands
    assign r1 = bank_r1[ thread ];
    assign r2 = bank_r2[ thread ];

    // sequencer index stays inside the banks
    assert property ( @( posedge clk ) disable iff ( !arst_n )
        wr_r1 || wr_r2 |-> thread < THREADS );

endmodule

// File: design/bind_permute_unit.sv
`timescale 1ns/100ps

module bind_permute_unit
    import hdc_cfg_pkg::*;
    import hdc_isa_pkg::*;
#(
    parameter int HV_BITS = HV_BITS_DFLT
) (
    input  logic [ HV_BITS-1:0 ] r1,
    input  logic [ HV_BITS-1:0 ] r2,
    input  logic [ HV_BITS-1:0 ] item_rdata,
    input  logic [ SHIFT_W-1:0 ] shift,
    input  nxt_sel_e             nxt_sel_r1,
    input  nxt_sel_e             nxt_sel_r2,
    output logic [ HV_BITS-1:0 ] perm,
    output logic [ HV_BITS-1:0 ] next_r1,
    output logic [ HV_BITS-1:0 ] next_r2
);

    logic [ SHIFT_W-1:0 ]   amt;
    logic [ 2*HV_BITS-1:0 ] twice;

    // shift field may exceed the vector length
    assign amt = SHIFT_W'( shift % HV_BITS );

    // rotate left, upper half of the doubled vector
    assign twice = { r1, r1 } << amt;
    assign perm  = twice[ 2*HV_BITS-1 -: HV_BITS ];

    function automatic logic [ HV_BITS-1:0 ] pick( nxt_sel_e sel );
        case ( sel )
            NXT_ITEM:        pick = item_rdata;
            NXT_XOR:         pick = r1 ^ r2;
            NXT_PERM_XOR_R2: pick = perm ^ r2;
            NXT_PERM_XOR_R1: pick = perm ^ r1;
            NXT_R1:          pick = r1;
            NXT_R2:          pick = r2;
            // plain permute
            default:         pick = perm;
        endcase
    endfunction

    // same mux for both registers, only the select differs
    always_comb begin
        next_r1 = pick( nxt_sel_r1 );
        next_r2 = pick( nxt_sel_r2 );
    end

endmodule

// File: design/result_output.sv
`timescale 1ns/100ps

module result_output
    import hdc_cfg_pkg::*;
    import hdc_isa_pkg::*;
#(
    parameter int HV_BITS = HV_BITS_DFLT
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 run,
    input  logic                 out_valid,
    input  out_sel_e             out_sel,
    input  logic                 last_req,
    input  logic [ HV_BITS-1:0 ] r1,
    input  logic [ HV_BITS-1:0 ] r2,
    input  logic [ HV_BITS-1:0 ] perm,
    output logic                 store,
    output logic [ HV_BITS-1:0 ] result,
    output logic                 last
);

    // first stage holds the picked vector, second drives the port
    logic [ HV_BITS-1:0 ] sel_vec;
    logic [ HV_BITS-1:0 ] buf_q;
    logic                 store_q;
    logic                 last_q;

    always_comb begin
        case ( out_sel )
            OSEL_R2: sel_vec = r2;
            OSEL_R1: sel_vec = r1;
            default: sel_vec = perm;
        endcase
    end

    always_ff @( posedge clk or negedge arst_n ) begin
        if ( !arst_n ) begin
            buf_q   <= '0;
            store_q <= 1'b0;
            last_q  <= 1'b0;
            result  <= '0;
            store   <= 1'b0;
            last    <= 1'b0;
        end else if ( !run ) begin
            // nothing leaves the core while paused
            buf_q   <= '0;
            store_q <= 1'b0;
            last_q  <= 1'b0;
            result  <= '0;
            store   <= 1'b0;
            last    <= 1'b0;
        end else begin
            // buffer stays empty without an output word, so result is zero outside store
            buf_q   <= out_valid ? sel_vec : '0;
            store_q <= out_valid;
            last_q  <= last_req;
            result  <= buf_q;
            store   <= store_q;
            last    <= last_q;
        end
    end

endmodule

// File: design/hdc_core.sv
`timescale 1ns/100ps

module hdc_core
    import hdc_cfg_pkg::*;
    import hdc_isa_pkg::*;
#(
    parameter int HV_BITS = HV_BITS_DFLT,
    parameter int ITEMS   = ITEMS_DFLT,
    parameter int THREADS = THREADS_DFLT
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 run,
    input  logic                 load,
    input  logic                 load_valid,
    input  logic [ WORD_W-1:0 ]  load_word,
    input  logic                 instr_valid,
    input  logic [ WORD_W-1:0 ]  instr_word,
    output logic                 store,
    output logic [ HV_BITS-1:0 ] result,
    output logic                 last
);

    localparam int ADDR_W = $clog2( ITEMS );
    localparam int TH_W   = $clog2( THREADS );

    // load path
    logic                 item_we;
    logic [ ADDR_W-1:0 ]  item_waddr;
    logic [ HV_BITS-1:0 ] item_wdata;
    logic [ HV_BITS-1:0 ] item_rdata;

    // decoded instruction
    logic [ TH_W-1:0 ]    thread;
    logic                 wr_r1;
    logic                 wr_r2;
    logic [ SHIFT_W-1:0 ] shift;
    nxt_sel_e             nxt_sel_r1;
    nxt_sel_e             nxt_sel_r2;
    logic                 out_valid;
    out_sel_e             out_sel;
    logic                 last_req;

    // thread registers and their next values
    logic [ HV_BITS-1:0 ] r1;
    logic [ HV_BITS-1:0 ] r2;
    logic [ HV_BITS-1:0 ] perm;
    logic [ HV_BITS-1:0 ] next_r1;
    logic [ HV_BITS-1:0 ] next_r2;

    item_loader #( .HV_BITS( HV_BITS ), .ITEMS( ITEMS ) ) i_item_loader (
        .clk, .arst_n, .load, .load_valid, .load_word,
        .item_we, .item_waddr, .item_wdata
    );

    // item address comes straight from the incoming word
    item_memory #( .HV_BITS( HV_BITS ), .ITEMS( ITEMS ) ) i_item_memory (
        .clk, .item_we, .item_waddr, .item_wdata,
        .item_raddr( instr_word[ ADDR_W-1:0 ] ),
        .item_rdata
    );

    hdc_sequencer #( .THREADS( THREADS ) ) i_hdc_sequencer (
        .clk, .arst_n, .run, .instr_valid, .instr_word,
        .thread, .wr_r1, .wr_r2, .shift, .nxt_sel_r1, .nxt_sel_r2,
        .out_valid, .out_sel, .last_req
    );

    thread_regfile #( .HV_BITS( HV_BITS ), .THREADS( THREADS ) ) i_thread_regfile (
        .clk, .arst_n, .thread, .wr_r1, .wr_r2, .next_r1, .next_r2, .r1, .r2
    );

    bind_permute_unit #( .HV_BITS( HV_BITS ) ) i_bind_permute_unit (
        .r1, .r2, .item_rdata, .shift, .nxt_sel_r1, .nxt_sel_r2,
        .perm, .next_r1, .next_r2
    );

    result_output #( .HV_BITS( HV_BITS ) ) i_result_output (
        .clk, .arst_n, .run, .out_valid, .out_sel, .last_req, .r1, .r2, .perm,
        .store, .result, .last
    );

endmodule

// File: testbench/hdc_core_tb.sv
`timescale 1ns/100ps

module hdc_core_tb
    import hdc_cfg_pkg::*;
    import hdc_isa_pkg::*;
();

    localparam int HV_BITS        = 256;
    localparam int ITEMS          = 16;
    localparam int THREADS        = 3;
    localparam int WORDS          = HV_BITS / WORD_W;
    localparam int ADDR_W         = $clog2( ITEMS );
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int SEED           = 32'h2800;

    logic                 clk;
    logic                 arst_n;
    logic                 run;
    logic                 load;
    logic                 load_valid;
    logic [ WORD_W-1:0 ]  load_word;
    logic                 instr_valid;
    logic [ WORD_W-1:0 ]  instr_word;
    logic                 store;
    logic [ HV_BITS-1:0 ] result;
    logic                 last;

    // reference state of the core
    logic [ HV_BITS-1:0 ] m_r1 [ THREADS ];
    logic [ HV_BITS-1:0 ] m_r2 [ THREADS ];
    logic [ HV_BITS-1:0 ] m_item [ ITEMS ];
    logic [ HV_BITS-1:0 ] exp_out;
    int                   next_thread;
    int                   errors;
    int                   checks;
    int                   cycles = 0;

    hdc_core #( .HV_BITS( HV_BITS ), .ITEMS( ITEMS ), .THREADS( THREADS ) ) i_hdc_core (
        .clk, .arst_n, .run, .load, .load_valid, .load_word,
        .instr_valid, .instr_word, .store, .result, .last
    );

    always #2 clk = ~clk;

    always @( posedge clk ) begin
        cycles <= cycles + 1;
        if ( cycles >= TIMEOUT_CYCLES ) begin
            $display( "timeout: run did not end within %0d cycles", TIMEOUT_CYCLES );
            $display( "Simulation failed" );
            $finish;
        end
    end

    task automatic compare_bit( input string name, input logic got, input logic exp );
        checks++;
        if ( got !== exp ) begin
            errors++;
            $display( "ERROR at %0t: %s expected %b got %b", $time, name, exp, got );
        end
    endtask

    task automatic compare_vec( input string name, input logic [ HV_BITS-1:0 ] got,
                                input logic [ HV_BITS-1:0 ] exp );
        checks++;
        if ( got !== exp ) begin
            errors++;
            $display( "ERROR at %0t: %s expected %h got %h", $time, name, exp, got );
        end
    endtask

    function automatic logic [ HV_BITS-1:0 ] rotl( input logic [ HV_BITS-1:0 ] v, input int s );
        logic [ HV_BITS-1:0 ] r;
        int                   i;
        for ( i = 0; i < HV_BITS; i++ ) begin
            r[ ( i + s ) % HV_BITS ] = v[ i ];
        end
        return r;
    endfunction

    function automatic logic [ WORD_W-1:0 ] cmp_word( input logic w1, input logic w2,
                                                      input int src, input int sh );
        logic [ WORD_W-1:0 ] w;
        w            = '0;
        w[ 31 ]      = w1;
        w[ 30 ]      = w2;
        w[ 12+src ]  = 1'b1;
        w[ 9:0 ]     = 10'( sh );
        return w;
    endfunction

    function automatic logic [ WORD_W-1:0 ] out_word( input int sel, input int sh );
        logic [ WORD_W-1:0 ] w;
        w            = '0;
        w[ 28 ]      = 1'b1;
        w[ 12+sel ]  = 1'b1;
        w[ 9:0 ]     = 10'( sh );
        return w;
    endfunction

    // applies one instruction to the reference state
    task automatic model_exec( input logic [ WORD_W-1:0 ] w );
        logic [ HV_BITS-1:0 ] a;
        logic [ HV_BITS-1:0 ] b;
        logic [ HV_BITS-1:0 ] p;
        logic [ HV_BITS-1:0 ] v;
        a       = m_r1[ next_thread ];
        b       = m_r2[ next_thread ];
        p       = rotl( a, int'( w[ 9:0 ] ) );
        exp_out = '0;
        if ( w[ 28 ] ) begin
            if ( w[ 12+OUT_R2 ] )
                exp_out = b;
            else if ( w[ 12+OUT_R1 ] )
                exp_out = a;
            else if ( w[ 12+OUT_PERM ] )
                exp_out = p;
        end else begin
            if ( w[ 12+SRC_ITEM ] )
                v = m_item[ w[ ADDR_W-1:0 ] ];
            else if ( w[ 12+SRC_XOR ] )
                v = a ^ b;
            else if ( w[ 12+SRC_PERM_XOR_R2 ] )
                v = p ^ b;
            else if ( w[ 12+SRC_PERM_XOR_R1 ] )
                v = p ^ a;
            else
                v = p;
            // swap crosses the two registers
            if ( w[ 31 ] )
                m_r1[ next_thread ] = w[ 12+SRC_SWAP ] ? b : v;
            if ( w[ 30 ] )
                m_r2[ next_thread ] = w[ 12+SRC_SWAP ] ? a : v;
        end
        next_thread = ( next_thread + 1 ) % THREADS;
    endtask

    task automatic send( input logic [ WORD_W-1:0 ] w );
        @( posedge clk );
        instr_valid <= 1'b1;
        instr_word  <= w;
        model_exec( w );
    endtask

    task automatic quiet( input int n );
        repeat ( n ) begin
            @( posedge clk );
            instr_valid <= 1'b0;
            instr_word  <= '0;
        end
    endtask

    // no-ops until thread t is next in the round robin
    task automatic align( input int t );
        while ( next_thread != t )
            send( '0 );
    endtask

    task automatic load_items( input int n );
        logic [ HV_BITS-1:0 ] v;
        logic [ WORD_W-1:0 ]  wd;
        int                   i;
        int                   k;
        @( posedge clk );
        load <= 1'b1;
        for ( i = 0; i < n; i++ ) begin
            for ( k = 0; k < WORDS; k++ ) begin
                wd = $urandom;
                v[ k*WORD_W +: WORD_W ] = wd;
                @( posedge clk );
                load_valid <= 1'b1;
                load_word  <= wd;
            end
            m_item[ i ] = v;
        end
        @( posedge clk );
        load_valid <= 1'b0;
        repeat ( 3 ) @( posedge clk );
        load <= 1'b0;
    endtask

    // issues an output word and checks its strobe in the cycle after edge N+2
    task automatic read_result( input logic [ WORD_W-1:0 ] w );
        logic [ HV_BITS-1:0 ] exp;
        logic                 want_last;
        send( w );
        exp       = exp_out;
        want_last = w[ 12+OUT_LAST ];
        // edge N samples the word
        quiet( 1 );
        repeat ( 2 ) @( negedge clk );
        compare_bit( "store", store, 1'b0 );
        compare_bit( "last", last, 1'b0 );
        compare_vec( "result", result, '0 );
        @( negedge clk );
        compare_bit( "store", store, !want_last );
        compare_bit( "last", last, want_last );
        compare_vec( "result", result, want_last ? '0 : exp );
        // single cycle strobe
        @( negedge clk );
        compare_bit( "store", store, 1'b0 );
        compare_bit( "last", last, 1'b0 );
        compare_vec( "result", result, '0 );
    endtask

    task automatic fetch_and_read();
        int t;
        int i;
        load_items( 4 );
        for ( i = 0; i < 4; i++ ) begin
            t = next_thread;
            send( cmp_word( 1'b1, 1'b0, SRC_ITEM, i ) );
            align( t );
            read_result( out_word( OUT_R1, 0 ) );
        end
    endtask

    task automatic xor_bind();
        int t;
        t = next_thread;
        send( cmp_word( 1'b1, 1'b0, SRC_ITEM, 0 ) );
        align( t );
        send( cmp_word( 1'b0, 1'b1, SRC_ITEM, 1 ) );
        align( t );
        send( cmp_word( 1'b1, 1'b0, SRC_XOR, 0 ) );
        align( t );
        read_result( out_word( OUT_R1, 0 ) );
    endtask

    task automatic rotate_outputs();
        int shifts [ 8 ] = '{ 0, 1, 37, 128, 129, 200, 255, 300 };
        int t;
        int i;
        t = next_thread;
        send( cmp_word( 1'b1, 1'b0, SRC_ITEM, 2 ) );
        align( t );
        send( cmp_word( 1'b0, 1'b1, SRC_ITEM, 3 ) );
        for ( i = 0; i < 8; i++ ) begin
            align( t );
            read_result( out_word( OUT_PERM, shifts[ i ] ) );
        end
        align( t );
        send( cmp_word( 1'b0, 1'b1, SRC_PERM_XOR_R2, 77 ) );
        align( t );
        read_result( out_word( OUT_R2, 0 ) );
    endtask

    task automatic thread_isolation();
        int i;
        load_items( 3 );
        // six back to back writes over all threads
        for ( i = 0; i < 3; i++ )
            send( cmp_word( 1'b1, 1'b0, SRC_ITEM, i ) );
        for ( i = 0; i < 3; i++ )
            send( cmp_word( 1'b0, 1'b1, SRC_ITEM, 3 - i ) );
        for ( i = 0; i < THREADS; i++ ) begin
            align( i );
            read_result( out_word( OUT_R1, 0 ) );
            align( i );
            read_result( out_word( OUT_R2, 0 ) );
        end
    endtask

    task automatic last_and_pause();
        int i;
        read_result( out_word( OUT_LAST, 0 ) );
        @( posedge clk );
        run <= 1'b0;
        // ignored while run is low
        for ( i = 0; i < 6; i++ ) begin
            @( posedge clk );
            instr_valid <= 1'b1;
            instr_word  <= ( i % 2 ) ? out_word( OUT_R1, 0 ) : cmp_word( 1'b1, 1'b1, SRC_ITEM, i );
            @( negedge clk );
            compare_bit( "store", store, 1'b0 );
            compare_bit( "last", last, 1'b0 );
            compare_vec( "result", result, '0 );
        end
        quiet( 2 );
        @( posedge clk );
        run <= 1'b1;
        next_thread = 0;
        read_result( out_word( OUT_R1, 0 ) );
        align( 1 );
        read_result( out_word( OUT_R2, 0 ) );
    endtask

    initial begin
        void'( $urandom( SEED ) );
        clk         = 1'b0;
        arst_n      <= 1'b0;
        run         <= 1'b0;
        load        <= 1'b0;
        load_valid  <= 1'b0;
        load_word   <= '0;
        instr_valid <= 1'b0;
        instr_word  <= '0;
        next_thread = 0;
        errors      = 0;
        checks      = 0;
        repeat ( 2 ) @( posedge clk );
        arst_n <= 1'b1;
        @( negedge clk );
        compare_bit( "store", store, 1'b0 );
        compare_bit( "last", last, 1'b0 );
        compare_vec( "result", result, '0 );
        @( posedge clk );
        run <= 1'b1;
        fetch_and_read();
        xor_bind();
        rotate_outputs();
        thread_isolation();
        last_and_pause();
        quiet( 4 );
        $display( "checks: %0d, errors: %0d", checks, errors );
        if ( errors == 0 )
            $display( "Simulation completed successfully" );
        else
            $display( "Simulation failed" );
        $finish;
    end

endmodule

// File: hdc_core.f
design/hdc_cfg_pkg.sv
design/hdc_isa_pkg.sv
design/item_loader.sv
design/item_memory.sv
design/hdc_sequencer.sv
design/thread_regfile.sv
design/bind_permute_unit.sv
design/result_output.sv
design/hdc_core.sv
testbench/hdc_core_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module hdc_core_tb -f hdc_core.f -Mdir obj_dir
./obj_dir/Vhdc_core_tb | tee sim.log

if grep -q "Simulation completed successfully" sim.log; then
    echo "run passed"
else
    echo "run failed, see sim.log"
    exit 1
fi
